//--- Makefile
# Verilator build and run of the sprite line renderer testbench

VERILATOR ?= verilator
TOP       ?= obj_line_tb
FILELIST  ?= sim.f
BUILD_DIR ?= build
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/obj_config.svh
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// sprite table and queue sizes
`define OBJ_SPRITES     256
`define OBJ_PRIORITIES  16
`define OBJ_IDX_W       8       // sprite index bits
`define OBJ_PRIO_W      4

// line geometry
`define OBJ_LINE_W      320     // visible pixels, wider x is clipped
`define OBJ_BUF_DEPTH   512     // entries per buffer half

// external bus widths
`define OBJ_ATTR_AW     10      // four 16-bit words per sprite
`define OBJ_TILE_AW     16      // tile offset below the tile number
`define OBJ_PIXEL_W     15      // prio, palette and pen

`endif

//--- logic/obj_line_buffer.sv
`default_nettype none

`include "obj_config.svh"

module obj_line_buffer (
    input  wire logic           clk96_i,
    input  wire logic           reset96_i,
    input  wire logic           swap_i,
    input  wire obj_pkg::obj_wr_t wr_i,
    input  wire logic           rd_en_i,
    input  wire logic [8:0]     rd_x_i,
    output obj_pkg::obj_pixel_t pixel_o
);

    // both halves in one array, the top address bit picks the half
    logic [`OBJ_PIXEL_W-1:0] mem [2 * `OBJ_BUF_DEPTH];
    logic                    disp_q;    // half on the display side

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            disp_q  <= 1'b0;
            pixel_o <= '0;
        end else begin
            if (swap_i) disp_q <= ~disp_q;
            if (rd_en_i) pixel_o <= mem[{disp_q, rd_x_i}];
        end
    end

    // render port writes, display port clears what it read
    always_ff @(posedge clk96_i) begin
        if (wr_i.we)
            mem[{~disp_q, wr_i.addr}] <= wr_i.pixel;
        if (rd_en_i)
            mem[{disp_q, rd_x_i}] <= '0;
    end

endmodule

`default_nettype wire

//--- logic/obj_line_top.sv
`default_nettype none

`include "obj_config.svh"

module obj_line_top (
    input  wire logic                    clk96_i,
    input  wire logic                    reset96_i,
    input  wire logic                    line_start_i,
    input  wire logic [8:0]              line_i,
    output logic [`OBJ_ATTR_AW-1:0]      attr_addr_a_o,
    output logic [`OBJ_ATTR_AW-1:0]      attr_addr_b_o,
    input  wire logic [15:0]             attr_dout_a_i,
    input  wire logic [15:0]             attr_dout_b_i,
    output logic                         gfx_cs_o,
    output logic [30:0]                  gfx_addr_o,
    input  wire logic                    gfx_ok_i,
    input  wire logic [31:0]             gfx_data_i,
    input  wire logic                    rd_en_i,
    input  wire logic [8:0]              rd_x_i,
    output obj_pkg::obj_pixel_t          pixel_o,
    output logic                         busy_o,
    output logic                         done_o
);
    import obj_pkg::*;

    obj_push_t push;
    obj_wr_t   wr;

    logic                   swap;
    logic                   q_done, q_empty, slot_rd;
    logic [`OBJ_PRIO_W-1:0] q_prio;
    logic [`OBJ_IDX_W:0]    q_count;
    logic [`OBJ_IDX_W-1:0]  slot_idx;

    // counter controls and counts
    logic                   sprite_clr, sprite_step, slot_clr, slot_step;
    logic                   tile_clr, tile_step, col_clr, col_step;
    logic [3:0]             x_size;
    logic                   xflip;
    logic [`OBJ_IDX_W-1:0]  sprite;
    logic [`OBJ_IDX_W:0]    slot;
    logic [3:0]             tile;
    logic [2:0]             col;
    logic                   col_last, tile_last;

    obj_sequencer u_seq (
        .clk96_i       (clk96_i),       .reset96_i     (reset96_i),
        .line_start_i  (line_start_i),  .line_i        (line_i),
        .attr_addr_a_o (attr_addr_a_o), .attr_addr_b_o (attr_addr_b_o),
        .attr_dout_a_i (attr_dout_a_i), .attr_dout_b_i (attr_dout_b_i),
        .gfx_cs_o      (gfx_cs_o),      .gfx_addr_o    (gfx_addr_o),
        .gfx_ok_i      (gfx_ok_i),      .gfx_data_i    (gfx_data_i),
        .sprite_clr_o  (sprite_clr),    .sprite_step_o (sprite_step),
        .slot_clr_o    (slot_clr),      .slot_step_o   (slot_step),
        .tile_clr_o    (tile_clr),      .tile_step_o   (tile_step),
        .col_clr_o     (col_clr),       .col_step_o    (col_step),
        .x_size_o      (x_size),        .xflip_o       (xflip),
        .sprite_i      (sprite),        .slot_i        (slot),
        .tile_i        (tile),          .col_i         (col),
        .col_last_i    (col_last),      .tile_last_i   (tile_last),
        .push_o        (push),          .q_done_o      (q_done),
        .q_empty_i     (q_empty),       .q_prio_i      (q_prio),
        .q_count_i     (q_count),       .slot_rd_o     (slot_rd),
        .slot_idx_i    (slot_idx),      .wr_o          (wr),
        .swap_o        (swap),          .busy_o        (busy_o),
        .done_o        (done_o)
    );

    obj_slot_counter u_cnt (
        .clk96_i       (clk96_i),       .reset96_i     (reset96_i),
        .sprite_clr_i  (sprite_clr),    .sprite_step_i (sprite_step),
        .slot_clr_i    (slot_clr),      .slot_step_i   (slot_step),
        .tile_clr_i    (tile_clr),      .tile_step_i   (tile_step),
        .col_clr_i     (col_clr),       .col_step_i    (col_step),
        .x_size_i      (x_size),        .xflip_i       (xflip),
        .sprite_o      (sprite),        .slot_o        (slot),
        .tile_o        (tile),          .col_o         (col),
        .col_last_o    (col_last),      .tile_last_o   (tile_last)
    );

    // queue empties at the same strobe that swaps the buffer
    obj_priority_queue u_queue (
        .clk96_i     (clk96_i),     .reset96_i   (reset96_i),
        .clear_i     (swap),        .push_i      (push),
        .done_prio_i (q_done),      .rd_i        (slot_rd),
        .slot_i      (slot[`OBJ_IDX_W-1:0]),
        .empty_o     (q_empty),     .prio_o      (q_prio),
        .count_o     (q_count),     .idx_o       (slot_idx)
    );

    obj_line_buffer u_lbuf (
        .clk96_i   (clk96_i),   .reset96_i (reset96_i),
        .swap_i    (swap),      .wr_i      (wr),
        .rd_en_i   (rd_en_i),   .rd_x_i    (rd_x_i),
        .pixel_o   (pixel_o)
    );

endmodule

`default_nettype wire

//--- logic/obj_pkg.sv
`default_nettype none

`include "obj_config.svh"

package obj_pkg;

    typedef enum logic [3:0] {
        idle,
        scan_addr,
        scan_wait,
        scan_check,
        pick,           // choose lowest pending priority
        slot_read,
        attr_addr,
        attr_wait,
        attr_load,
        tile_req,
        tile_wait,      // held ROM request
        draw,
        next_tile
    } obj_state_e;

    // attributes of the sprite being drawn
    typedef struct packed {
        logic                   active;
        logic                   xflip;
        logic [`OBJ_PRIO_W-1:0] prio;
        logic [6:0]             palette;
        logic [14:0]            tile_num;
        logic [3:0]             x_size;     // tiles minus one
        logic [3:0]             y_size;
        logic [8:0]             x_pos;
        logic [8:0]             y_pos;
    } obj_attr_t;

    typedef struct packed {
        logic [`OBJ_PRIO_W-1:0] prio;
        logic [6:0]             palette;
        logic [3:0]             pen;        // 0 is transparent
    } obj_pixel_t;

    typedef struct packed {
        logic       we;
        logic [8:0] addr;
        obj_pixel_t pixel;
    } obj_wr_t;

    typedef struct packed {
        logic                   push;
        logic [`OBJ_PRIO_W-1:0] prio;
        logic [`OBJ_IDX_W-1:0]  idx;
    } obj_push_t;

endpackage

`default_nettype wire

//--- logic/obj_priority_queue.sv
`default_nettype none

`include "obj_config.svh"

module obj_priority_queue (
    input  wire logic                   clk96_i,
    input  wire logic                   reset96_i,
    input  wire logic                   clear_i,
    input  wire obj_pkg::obj_push_t     push_i,
    input  wire logic                   done_prio_i,    // retire the lowest level
    input  wire logic                   rd_i,
    input  wire logic [`OBJ_IDX_W-1:0]  slot_i,
    output logic                        empty_o,
    output logic [`OBJ_PRIO_W-1:0]      prio_o,
    output logic [`OBJ_IDX_W:0]         count_o,
    output logic [`OBJ_IDX_W-1:0]       idx_o
);

    // one list of sprite indices per level
    logic [`OBJ_IDX_W-1:0]   mem [`OBJ_PRIORITIES * `OBJ_SPRITES];
    logic [`OBJ_IDX_W:0]     counts [`OBJ_PRIORITIES];
    logic [`OBJ_PRIORITIES-1:0] pending;

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            pending <= '0;
            for (int p = 0; p < `OBJ_PRIORITIES; p++) counts[p] <= '0;
        end else if (clear_i) begin
            pending <= '0;
            for (int p = 0; p < `OBJ_PRIORITIES; p++) counts[p] <= '0;
        end else begin
            if (push_i.push) begin
                counts[push_i.prio]  <= counts[push_i.prio] + 1'b1;
                pending[push_i.prio] <= 1'b1;
            end
            if (done_prio_i) pending[prio_o] <= 1'b0;
        end
    end

    always_ff @(posedge clk96_i) begin
        if (push_i.push)
            mem[{push_i.prio, counts[push_i.prio][`OBJ_IDX_W-1:0]}] <= push_i.idx;
        if (rd_i)
            idx_o <= mem[{prio_o, slot_i}];     // one cycle read
    end

    // lowest pending level wins, so scan from the top down
    always_comb begin
        prio_o = '0;
        for (int p = `OBJ_PRIORITIES - 1; p >= 0; p--) begin
            if (pending[p]) prio_o = `OBJ_PRIO_W'(p);
        end
    end

    assign empty_o = ~|pending;
    assign count_o = counts[prio_o];

endmodule

`default_nettype wire

//--- logic/obj_sequencer.sv
`default_nettype none

`include "obj_config.svh"

module obj_sequencer (
    input  wire logic                    clk96_i,
    input  wire logic                    reset96_i,
    input  wire logic                    line_start_i,
    input  wire logic [8:0]              line_i,
    output logic [`OBJ_ATTR_AW-1:0]      attr_addr_a_o,
    output logic [`OBJ_ATTR_AW-1:0]      attr_addr_b_o,
    input  wire logic [15:0]             attr_dout_a_i,
    input  wire logic [15:0]             attr_dout_b_i,
    output logic                         gfx_cs_o,
    output logic [30:0]                  gfx_addr_o,
    input  wire logic                    gfx_ok_i,
    input  wire logic [31:0]             gfx_data_i,
    output logic                         sprite_clr_o,
    output logic                         sprite_step_o,
    output logic                         slot_clr_o,
    output logic                         slot_step_o,
    output logic                         tile_clr_o,
    output logic                         tile_step_o,
    output logic                         col_clr_o,
    output logic                         col_step_o,
    output logic [3:0]                   x_size_o,
    output logic                         xflip_o,
    input  wire logic [`OBJ_IDX_W-1:0]   sprite_i,
    input  wire logic [`OBJ_IDX_W:0]     slot_i,
    input  wire logic [3:0]              tile_i,
    input  wire logic [2:0]              col_i,
    input  wire logic                    col_last_i,
    input  wire logic                    tile_last_i,
    output obj_pkg::obj_push_t           push_o,
    output logic                         q_done_o,
    input  wire logic                    q_empty_i,
    input  wire logic [`OBJ_PRIO_W-1:0]  q_prio_i,
    input  wire logic [`OBJ_IDX_W:0]     q_count_i,
    output logic                         slot_rd_o,
    input  wire logic [`OBJ_IDX_W-1:0]   slot_idx_i,
    output obj_pkg::obj_wr_t             wr_o,
    output logic                         swap_o,
    output logic                         busy_o,
    output logic                         done_o
);
    import obj_pkg::*;

    obj_state_e state_q;
    obj_attr_t  attr_q;

    logic [8:0]             line_q;
    logic [`OBJ_IDX_W-1:0]  idx_q;
    logic [31:0]            slice_q;

    logic [8:0]             scan_row, row;
    logic                   scan_hit, sprite_last, slot_more;
    logic [12:0]            slice_idx;
    logic [`OBJ_TILE_AW-1:0] tile_offs;
    logic [2:0]             scol;
    logic [3:0]             pen;
    logic [9:0]             pix_x;

    // vertical coverage, modulo 512
    assign scan_row    = line_q - attr_dout_b_i[15:7];
    assign scan_hit    = attr_dout_a_i[15] && (scan_row[8:3] <= {2'b00, attr_dout_b_i[3:0]});
    assign sprite_last = sprite_i == `OBJ_IDX_W'(`OBJ_SPRITES - 1);
    assign slot_more   = slot_i < q_count_i;

    // slice address inside the tile block
    assign row       = line_q - attr_q.y_pos;
    assign slice_idx = 13'(row[8:3]) * (13'(attr_q.x_size) + 13'd1) + 13'(tile_i);
    assign tile_offs = {slice_idx, row[2:0]};

    assign scol  = attr_q.xflip ? ~col_i : col_i;  // screen column of this pen
    assign pen   = slice_q[{col_i, 2'b00} +: 4];
    assign pix_x = {1'b0, attr_q.x_pos} + {3'b000, tile_i, 3'b000} + {7'd0, scol};

    assign swap_o   = (state_q == idle) && line_start_i;
    assign xflip_o  = attr_q.xflip;
    assign x_size_o = attr_q.x_size;

    assign push_o = '{push: (state_q == scan_check) && scan_hit,
                      prio: attr_dout_a_i[11:8],
                      idx:  sprite_i};

    always_comb begin
        case (state_q)
            attr_addr: begin                    // words 0 and 1
                attr_addr_a_o = {slot_idx_i, 2'd0};
                attr_addr_b_o = {slot_idx_i, 2'd1};
            end
            attr_wait: begin                    // words 2 and 3
                attr_addr_a_o = {idx_q, 2'd2};
                attr_addr_b_o = {idx_q, 2'd3};
            end
            default: begin                      // scan reads words 0 and 3
                attr_addr_a_o = {sprite_i, 2'd0};
                attr_addr_b_o = {sprite_i, 2'd3};
            end
        endcase
    end

    always_comb begin
        sprite_clr_o  = swap_o;
        sprite_step_o = (state_q == scan_check) && !sprite_last;
        q_done_o      = (state_q == pick) && !q_empty_i && !slot_more;
        slot_clr_o    = ((state_q == scan_check) && sprite_last) || q_done_o;
        slot_step_o   = (state_q == next_tile) && tile_last_i;
        slot_rd_o     = state_q == slot_read;
        tile_clr_o    = state_q == attr_load;
        tile_step_o   = (state_q == next_tile) && !tile_last_i;
        col_clr_o     = tile_clr_o || tile_step_o;
        col_step_o    = state_q == draw;
    end

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            state_q  <= idle;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
            gfx_cs_o <= 1'b0;
            wr_o     <= '0;
        end else begin
            done_o  <= 1'b0;
            wr_o.we <= 1'b0;
            case (state_q)
                idle: begin
                    if (line_start_i) begin
                        busy_o  <= 1'b1;
                        state_q <= scan_addr;
                    end
                end
                scan_addr:  state_q <= scan_wait;
                scan_wait:  state_q <= scan_check;
                scan_check: state_q <= sprite_last ? pick : scan_addr;
                pick: begin
                    if (q_empty_i) begin        // all levels walked
                        busy_o  <= 1'b0;
                        done_o  <= 1'b1;
                        state_q <= idle;
                    end else if (slot_more) begin
                        state_q <= slot_read;
                    end
                end
                slot_read: state_q <= attr_addr;
                attr_addr: state_q <= attr_wait;
                attr_wait: state_q <= attr_load;
                attr_load: state_q <= tile_req;
                tile_req: begin
                    gfx_cs_o <= 1'b1;
                    state_q  <= tile_wait;
                end
                tile_wait: begin
                    if (gfx_ok_i) begin
                        gfx_cs_o <= 1'b0;
                        state_q  <= draw;
                    end
                end
                draw: begin
                    wr_o.we    <= attr_q.active && (pen != 4'd0) && (pix_x < 10'(`OBJ_LINE_W));
                    wr_o.addr  <= pix_x[8:0];
                    wr_o.pixel <= '{prio: attr_q.prio, palette: attr_q.palette, pen: pen};
                    if (col_last_i) state_q <= next_tile;
                end
                next_tile: state_q <= tile_last_i ? pick : tile_req;
                default:   state_q <= idle;
            endcase
        end
    end

    always_ff @(posedge clk96_i) begin
        case (state_q)
            idle:      if (line_start_i) line_q <= line_i;
            attr_addr: idx_q <= slot_idx_i;
            attr_wait: begin
                attr_q.active   <= attr_dout_a_i[15];
                attr_q.xflip    <= attr_dout_a_i[12];
                attr_q.prio     <= q_prio_i;        // queue level is the sprite priority
                attr_q.palette  <= attr_dout_a_i[6:0];
                attr_q.tile_num <= attr_dout_b_i[14:0];
            end
            attr_load: begin
                attr_q.x_pos  <= attr_dout_a_i[15:7];
                attr_q.x_size <= attr_dout_a_i[3:0];
                attr_q.y_pos  <= attr_dout_b_i[15:7];
                attr_q.y_size <= attr_dout_b_i[3:0];
            end
            tile_req:  gfx_addr_o <= {attr_q.tile_num, tile_offs};
            tile_wait: if (gfx_ok_i) slice_q <= gfx_data_i;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/obj_slot_counter.sv
`default_nettype none

`include "obj_config.svh"

module obj_slot_counter (
    input  wire logic                   clk96_i,
    input  wire logic                   reset96_i,
    input  wire logic                   sprite_clr_i,
    input  wire logic                   sprite_step_i,
    input  wire logic                   slot_clr_i,
    input  wire logic                   slot_step_i,
    input  wire logic                   tile_clr_i,
    input  wire logic                   tile_step_i,
    input  wire logic                   col_clr_i,
    input  wire logic                   col_step_i,
    input  wire logic [3:0]             x_size_i,   // last tile index
    input  wire logic                   xflip_i,
    output logic [`OBJ_IDX_W-1:0]       sprite_o,
    output logic [`OBJ_IDX_W:0]         slot_o,     // can reach a full level count
    output logic [3:0]                  tile_o,
    output logic [2:0]                  col_o,
    output logic                        col_last_o,
    output logic                        tile_last_o
);

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            sprite_o <= '0;
            slot_o   <= '0;
            tile_o   <= '0;
            col_o    <= '0;
        end else begin
            if (sprite_clr_i)       sprite_o <= '0;
            else if (sprite_step_i) sprite_o <= sprite_o + 1'b1;

            if (slot_clr_i)         slot_o <= '0;
            else if (slot_step_i)   slot_o <= slot_o + 1'b1;

            if (tile_clr_i)         tile_o <= '0;
            else if (tile_step_i)   tile_o <= tile_o + 1'b1;

            // pen index runs downward when flipped
            if (col_clr_i)          col_o <= xflip_i ? 3'd7 : 3'd0;
            else if (col_step_i)    col_o <= xflip_i ? col_o - 3'd1 : col_o + 3'd1;
        end
    end

    assign col_last_o  = col_o == (xflip_i ? 3'd0 : 3'd7);
    assign tile_last_o = tile_o == x_size_i;

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/obj_pkg.sv
logic/obj_slot_counter.sv
logic/obj_priority_queue.sv
logic/obj_line_buffer.sv
logic/obj_sequencer.sv
logic/obj_line_top.sv
tests/obj_line_tb.sv

//--- tests/obj_line_tb.sv
`default_nettype none

`include "obj_config.svh"

module obj_line_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RENDER_LIMIT = 20000;                // cycles allowed for one line
    localparam int RAND_LINES   = 4;
    localparam int RAND_SPRITES = 24;
    localparam int N_RENDERS    = 2 * (5 + RAND_LINES);
    localparam int N_READOUTS   = 7 + RAND_LINES;
    localparam int WATCHDOG_T   = CLK_PERIOD * (N_RENDERS * RENDER_LIMIT
                                  + N_READOUTS * (`OBJ_BUF_DEPTH + 8) + 1000);
    localparam logic [31:0] SEED = 32'h17b30637;

    logic        clk96;
    logic        reset96;
    logic        line_start_i;
    logic [8:0]  line_i;
    logic [9:0]  attr_addr_a_o, attr_addr_b_o;
    logic [15:0] attr_dout_a_i = 16'h0000;
    logic [15:0] attr_dout_b_i = 16'h0000;
    logic        gfx_cs_o;
    logic [30:0] gfx_addr_o;
    logic        gfx_ok_i = 1'b0;
    logic [31:0] gfx_data_i = 32'h0;
    logic        rd_en_i;
    logic [8:0]  rd_x_i;
    obj_pkg::obj_pixel_t pixel_o;
    logic        busy_o, done_o;

    logic [15:0] attr_mem [1024];               // four words per sprite
    logic [14:0] exp_line [`OBJ_LINE_W];
    logic [31:0] rng = SEED;                    // stimulus stream
    logic [31:0] lat_rng = SEED;                // ROM latency stream
    logic [1:0]  rom_phase = 2'd0;              // idle, waiting, answered
    logic [2:0]  rom_wait = 3'd0;

    int checks, test_errors, total_errors, passed, failed, starts;
    int dones = 0;

    obj_line_top dut0 (
        .clk96_i       (clk96),         .reset96_i     (reset96),
        .line_start_i  (line_start_i),  .line_i        (line_i),
        .attr_addr_a_o (attr_addr_a_o), .attr_addr_b_o (attr_addr_b_o),
        .attr_dout_a_i (attr_dout_a_i), .attr_dout_b_i (attr_dout_b_i),
        .gfx_cs_o      (gfx_cs_o),      .gfx_addr_o    (gfx_addr_o),
        .gfx_ok_i      (gfx_ok_i),      .gfx_data_i    (gfx_data_i),
        .rd_en_i       (rd_en_i),       .rd_x_i        (rd_x_i),
        .pixel_o       (pixel_o),       .busy_o        (busy_o),
        .done_o        (done_o)
    );

    initial begin
        clk96 = 1'b0;
        forever #(CLK_PERIOD / 2) clk96 = ~clk96;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = 32'h0;
        for (i = 0; i < n; i++) begin
            rng = lfsr_next(rng);
            v = {v[30:0], rng[0]};
        end
    endtask

    // graphics ROM contents, roughly half the pens transparent
    function automatic logic [31:0] rom_word(input logic [30:0] a);
        logic [31:0] s, d;
        int i;
        s = SEED ^ {a, 1'b0};
        for (i = 0; i < 20; i++) s = lfsr_next(s);
        d = s;
        for (i = 0; i < 8; i++) begin
            s = lfsr_next(s);
            if (s[0]) d[4*i +: 4] = 4'h0;
        end
        return d;
    endfunction

    always @(posedge clk96) begin                   // attribute RAM, one cycle read
        attr_dout_a_i <= attr_mem[attr_addr_a_o];
        attr_dout_b_i <= attr_mem[attr_addr_b_o];
    end

    always @(posedge clk96) begin
        gfx_ok_i <= 1'b0;
        if (!gfx_cs_o) begin
            rom_phase <= 2'd0;
        end else if (rom_phase == 2'd0) begin       // new request, pick a delay
            lat_rng = lfsr_next(lat_rng);
            lat_rng = lfsr_next(lat_rng);
            lat_rng = lfsr_next(lat_rng);
            rom_wait  <= lat_rng[2:0];
            rom_phase <= 2'd1;
        end else if (rom_phase == 2'd1) begin
            if (rom_wait == 3'd0) begin
                gfx_ok_i   <= 1'b1;
                gfx_data_i <= rom_word(gfx_addr_o);
                rom_phase  <= 2'd2;
            end else begin
                rom_wait <= rom_wait - 3'd1;
            end
        end
    end

    always @(posedge clk96) if (done_o) dones++;

    initial begin
        #(WATCHDOG_T);
        $display("watchdog expired after %0d time units, the run is stuck", WATCHDOG_T);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic clear_table();
        int i;
        for (i = 0; i < 1024; i++) attr_mem[i] = 16'h0000;
    endtask

    task automatic put_sprite(input logic [7:0] n, input logic act, input logic xf,
                              input logic [3:0] prio, input logic [6:0] pal,
                              input logic [14:0] tile, input logic [8:0] xpos,
                              input logic [3:0] xs, input logic [8:0] ypos,
                              input logic [3:0] ys);
        attr_mem[{n, 2'd0}] = {act, 2'b00, xf, prio, 1'b0, pal};
        attr_mem[{n, 2'd1}] = {1'b0, tile};
        attr_mem[{n, 2'd2}] = {xpos, 3'b000, xs};
        attr_mem[{n, 2'd3}] = {ypos, 3'b000, ys};
    endtask

    task automatic zero_expected();
        int i;
        for (i = 0; i < `OBJ_LINE_W; i++) exp_line[i] = 15'h0;
    endtask

    // reference renderer, level 0 first and index ascending, later writes win
    task automatic build_expected(input logic [8:0] line);
        logic [15:0] w0, w1, w2, w3;
        logic [8:0]  row;
        logic [3:0]  xs, pen;
        logic [31:0] data;
        int p, n, t, k, offs, x;
        zero_expected();
        for (p = 0; p < `OBJ_PRIORITIES; p++) begin
            for (n = 0; n < `OBJ_SPRITES; n++) begin
                w0  = attr_mem[10'(4 * n)];
                w1  = attr_mem[10'(4 * n + 1)];
                w2  = attr_mem[10'(4 * n + 2)];
                w3  = attr_mem[10'(4 * n + 3)];
                xs  = w2[3:0];
                row = line - w3[15:7];              // wraps modulo 512
                if (w0[15] && int'(w0[11:8]) == p && int'(row[8:3]) <= int'(w3[3:0])) begin
                    for (t = 0; t <= int'(xs); t++) begin
                        offs = (int'(row[8:3]) * (int'(xs) + 1) + t) * 8 + int'(row[2:0]);
                        data = rom_word({w1[14:0], offs[15:0]});
                        for (k = 0; k < 8; k++) begin
                            pen = w0[12] ? data[4*(7-k) +: 4] : data[4*k +: 4];
                            x   = int'(w2[15:7]) + 8 * t + k;
                            if (pen != 4'h0 && x < `OBJ_LINE_W)
                                exp_line[9'(x)] = {w0[11:8], w0[6:0], pen};
                        end
                    end
                end
            end
        end
    endtask

    task automatic render_line(input logic [8:0] line);
        int n;
        @(posedge clk96);
        line_start_i <= 1'b1;
        line_i       <= line;
        starts++;
        @(posedge clk96);
        line_start_i <= 1'b0;
        n = 0;
        while (!done_o && n < RENDER_LIMIT) begin
            @(posedge clk96);
            n++;
            if (!done_o)
                check_val("busy_o", 32'(busy_o), 32'd1);    // high from the cycle after the strobe
        end
        if (!done_o) begin
            $display("render of line %0d did not finish within %0d cycles", line, RENDER_LIMIT);
            test_errors++;
        end else begin
            check_val("busy_o", 32'(busy_o), 32'd0);        // falls together with done_o
        end
    endtask

    // pixel_o of x driven at one edge is sampled two edges later
    task automatic read_line(input int count);
        int i;
        logic [14:0] exp_pix;
        for (i = 0; i < count + 2; i++) begin
            @(posedge clk96);
            if (i >= 2) begin
                if (i - 2 < `OBJ_LINE_W)
                    exp_pix = exp_line[9'(i - 2)];
                else
                    exp_pix = 15'h0;                // beyond the visible line nothing is drawn
                check_val($sformatf("pixel_o[x=%0d]", i - 2), 32'(pixel_o), 32'(exp_pix));
            end
            if (i < count) begin
                rd_en_i <= 1'b1;
                rd_x_i  <= 9'(i);
            end else begin
                rd_en_i <= 1'b0;
            end
        end
    endtask

    task automatic line_test(input logic [8:0] line);
        build_expected(line);
        render_line(line);
        render_line(line);              // brings the drawn half to the display side
        read_line(`OBJ_LINE_W);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            passed++;
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic test_random();
        logic [31:0] v, idx, act, xf, prio, pal, tile, xp, xs, yd, ys;
        logic [8:0]  line;
        int l, s;
        for (l = 0; l < RAND_LINES; l++) begin
            clear_table();
            take_bits(9, v);
            line = v[8:0];
            for (s = 0; s < RAND_SPRITES; s++) begin
                take_bits(8, idx);
                take_bits(2, act);
                take_bits(1, xf);
                take_bits(4, prio);
                take_bits(7, pal);
                take_bits(15, tile);
                take_bits(9, xp);
                take_bits(2, xs);
                take_bits(6, yd);
                take_bits(3, ys);
                put_sprite(idx[7:0], act[1:0] != 2'd0, xf[0], prio[3:0], pal[6:0], tile[14:0],
                           xp[8:0], {2'b00, xs[1:0]}, line - yd[8:0], {1'b0, ys[2:0]});
            end
            line_test(line);
        end
        check_val("done_o pulse count", 32'(dones), 32'(starts));
        finish_test("random");
    endtask

    initial begin
        reset96      = 1'b1;
        line_start_i = 1'b0;
        line_i       = 9'd0;
        rd_en_i      = 1'b0;
        rd_x_i       = 9'd0;
        clear_table();
        repeat (10) @(posedge clk96);
        reset96 <= 1'b0;
        @(posedge clk96);

        check_val("busy_o", 32'(busy_o), 32'd0);
        check_val("done_o", 32'(done_o), 32'd0);
        check_val("gfx_cs_o", 32'(gfx_cs_o), 32'd0);
        zero_expected();
        read_line(`OBJ_BUF_DEPTH);
        finish_test("reset");

        clear_table();
        put_sprite(8'd5, 1'b1, 1'b0, 4'd2, 7'h15, 15'h0123, 9'd40, 4'd2, 9'd90, 4'd1);
        put_sprite(8'd6, 1'b0, 1'b0, 4'd7, 7'h16, 15'h0124, 9'd44, 4'd1, 9'd96, 4'd0);
        put_sprite(8'd7, 1'b1, 1'b0, 4'd8, 7'h17, 15'h0125, 9'd60, 4'd1, 9'd200, 4'd0);
        line_test(9'd100);
        finish_test("single");

        clear_table();
        put_sprite(8'd0, 1'b0, 1'b0, 4'd1, 7'h01, 15'h0200, 9'd8, 4'd3, 9'd30, 4'd2);
        put_sprite(8'd1, 1'b1, 1'b0, 4'd2, 7'h02, 15'h0201, 9'd8, 4'd15, 9'd34, 4'd15);
        put_sprite(8'd2, 1'b1, 1'b0, 4'd3, 7'h03, 15'h0202, 9'd70, 4'd2, 9'd10, 4'd1);
        line_test(9'd33);
        finish_test("no_cover");

        clear_table();
        put_sprite(8'd200, 1'b1, 1'b0, 4'd0, 7'h01, 15'h0010, 9'd96, 4'd3, 9'd48, 4'd0);
        put_sprite(8'd3, 1'b1, 1'b0, 4'd5, 7'h22, 15'h0020, 9'd100, 4'd1, 9'd48, 4'd0);
        put_sprite(8'd9, 1'b1, 1'b0, 4'd5, 7'h33, 15'h0030, 9'd104, 4'd1, 9'd45, 4'd0);
        put_sprite(8'd2, 1'b1, 1'b0, 4'd9, 7'h44, 15'h0040, 9'd110, 4'd0, 9'd50, 4'd0);
        line_test(9'd50);
        finish_test("overlap");

        clear_table();
        put_sprite(8'd20, 1'b1, 1'b0, 4'd3, 7'h05, 15'h0400, 9'd16, 4'd1, 9'd0, 4'd0);
        put_sprite(8'd21, 1'b1, 1'b1, 4'd3, 7'h06, 15'h0400, 9'd64, 4'd1, 9'd0, 4'd0);
        put_sprite(8'd22, 1'b1, 1'b1, 4'd4, 7'h07, 15'h1234, 9'd130, 4'd3, 9'd500, 4'd2);
        line_test(9'd7);
        finish_test("xflip");

        clear_table();
        put_sprite(8'd40, 1'b1, 1'b0, 4'd2, 7'h11, 15'h0abc, 9'd300, 4'd3, 9'd296, 4'd0);
        put_sprite(8'd41, 1'b1, 1'b1, 4'd6, 7'h12, 15'h0abd, 9'd500, 4'd15, 9'd290, 4'd1);
        line_test(9'd300);
        zero_expected();
        read_line(`OBJ_BUF_DEPTH);                  // cleared by the first readout
        finish_test("clip");

        test_random();

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 passed, failed, checks, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
